//--- hdl/ahb_ram_pkg.sv
package ahb_ram_pkg;

    // One bus word. HWDATA, HRDATA and every RAM word use this width.
    typedef logic [31:0] data_t;

    // One enable bit per byte lane, bit 0 selects bits 7:0 of the word.
    typedef logic [3:0] byte_mask_t;

    // Transfer type as driven by the master on HTRANS.
    typedef logic [1:0] htrans_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // Transfer size.
    // Only the three sizes that fit into a 32-bit bus are named here.
    typedef logic [2:0] hsize_t;

    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;

    // States of the slave control FSM.
    // CTRL_WRITE marks a cycle in which a write data phase is being
    // completed, CTRL_STALL the single wait state of a read that hit
    // the word being written.
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'b00,
        CTRL_WRITE = 2'b01,
        CTRL_STALL = 2'b10
    } ctrl_state_t;

    // Everything the RAM needs to perform one write, except the address.
    typedef struct packed {
        logic       enable;  // Write strobe for the current cycle.
        byte_mask_t mask;    // Lanes to update.
        data_t      data;    // Write data, aligned to the byte lanes.
    } ram_write_t;

endpackage

//--- hdl/ahb_slave_ctrl.sv
module ahb_slave_ctrl #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      HSEL,
    input  logic [ADDR_WIDTH-1:0]     haddr,    // Word address of the address phase.
    input  ahb_ram_pkg::htrans_t      HTRANS,
    input  logic                      HWRITE,
    output logic                      HREADY,
    output logic                      read_enable,
    output logic [ADDR_WIDTH-1:0]     read_addr,
    output logic                      write_enable,
    output logic [ADDR_WIDTH-1:0]     write_addr,
    output logic                      write_request
);

    ahb_ram_pkg::ctrl_state_t state;
    ahb_ram_pkg::ctrl_state_t next_state;

    logic [ADDR_WIDTH-1:0] addr_q;        // Word address of the last accepted request.
    logic                  transfer;
    logic                  request;
    logic                  read_request;
    logic                  stall;
    logic                  collision;

    // BUSY and IDLE carry no data, so only NONSEQ and SEQ count as transfers.
    assign transfer = (HTRANS == ahb_ram_pkg::HTRANS_NONSEQ) ||
                      (HTRANS == ahb_ram_pkg::HTRANS_SEQ);

    // An address phase is only accepted while HREADY is high.
    // During the wait state the master holds its next address phase,
    // which must not be taken twice.
    assign request       = HSEL && transfer && HREADY;
    assign read_request  = request && !HWRITE;
    assign write_request = request && HWRITE;

    assign stall = (state == ahb_ram_pkg::CTRL_STALL);

    // Both strobes come straight from the state register.
    assign HREADY       = !stall;
    assign write_enable = (state == ahb_ram_pkg::CTRL_WRITE);
    assign write_addr   = addr_q;   // Only meaningful while write_enable is high.

    // A read that names the word whose write data is on the bus right now
    // would sample the RAM before the write lands.
    assign collision = read_request && write_enable && (haddr == addr_q);

    // The read port samples during the address phase.
    // In the wait state the held read address is read again, this time
    // after the write has been stored.
    assign read_enable = read_request || stall;
    assign read_addr   = stall ? addr_q : haddr;

    always_comb begin
        if (write_request) begin
            next_state = ahb_ram_pkg::CTRL_WRITE;
        end else if (collision) begin
            next_state = ahb_ram_pkg::CTRL_STALL;
        end else begin
            next_state = ahb_ram_pkg::CTRL_IDLE;  // Also leaves the wait state.
        end
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= ahb_ram_pkg::CTRL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // The address is kept for the data phase of a write and for the
    // repeated read in the wait state.
    always_ff @(posedge HCLK) begin
        if (request) begin
            addr_q <= haddr;
        end
    end

endmodule

//--- hdl/ahb_byte_lanes.sv
module ahb_byte_lanes (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      write_request,
    input  ahb_ram_pkg::hsize_t       HSIZE,
    input  logic [1:0]                addr_low,   // HADDR[1:0] of the address phase.
    output ahb_ram_pkg::byte_mask_t   write_mask
);

    ahb_ram_pkg::byte_mask_t lane_mask;

    // Lanes follow the little-endian byte order of the bus.
    // A halfword is picked by address bit 1 alone, since transfers are aligned.
    always_comb begin
        case (HSIZE)
            ahb_ram_pkg::HSIZE_BYTE: begin
                lane_mask = ahb_ram_pkg::byte_mask_t'(4'b0001 << addr_low);
            end
            ahb_ram_pkg::HSIZE_HALF: begin
                lane_mask = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            ahb_ram_pkg::HSIZE_WORD: begin
                lane_mask = 4'b1111;
            end
            default: begin
                // Sizes wider than the bus select no lane.
                lane_mask = '0;
            end
        endcase
    end

    // The mask is moved into the data phase so that it lines up with
    // write_enable and HWDATA.
    // Any cycle without an accepted write clears it.
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_mask <= '0;
        end else if (write_request) begin
            write_mask <= lane_mask;
        end else begin
            write_mask <= '0;
        end
    end

endmodule

//--- hdl/ram_bank.sv
module ram_bank #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      read_enable,
    input  logic [ADDR_WIDTH-1:0]     read_addr,
    input  logic [ADDR_WIDTH-1:0]     write_addr,
    input  ahb_ram_pkg::ram_write_t   wr,
    output ahb_ram_pkg::data_t        read_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int LANES = $bits(ahb_ram_pkg::byte_mask_t);

    ahb_ram_pkg::data_t mem [DEPTH];

    // Each lane is written on its own.
    // Untouched lanes keep their old contents.
    always_ff @(posedge HCLK) begin
        if (wr.enable) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (wr.mask[lane]) begin
                    mem[write_addr][lane*8 +: 8] <= wr.data[lane*8 +: 8];
                end
            end
        end
    end

    // A read in the same cycle as a write to the same word returns
    // the old contents.
    // The controller covers that case with its wait state.
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            read_data <= '0;
        end else if (read_enable) begin
            read_data <= mem[read_addr];   // Holds between reads.
        end
    end

endmodule

//--- hdl/ahb_ram.sv
module ahb_ram #(
    parameter int ADDR_WIDTH = 10     // Word address bits, 4 KB by default.
) (
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      HSEL,
    input  logic [ADDR_WIDTH+1:0]     HADDR,
    input  ahb_ram_pkg::htrans_t      HTRANS,
    input  ahb_ram_pkg::hsize_t       HSIZE,
    input  logic                      HWRITE,
    input  ahb_ram_pkg::data_t        HWDATA,
    output logic                      HREADY,
    output ahb_ram_pkg::data_t        HRDATA
);

    logic [ADDR_WIDTH-1:0]     word_addr;
    logic [1:0]                byte_addr;
    logic                      read_enable;
    logic [ADDR_WIDTH-1:0]     read_addr;
    logic                      write_enable;
    logic [ADDR_WIDTH-1:0]     write_addr;
    logic                      write_request;
    ahb_ram_pkg::byte_mask_t   write_mask;
    ahb_ram_pkg::ram_write_t   ram_wr;

    // The word address drives the RAM.
    // The byte offset only picks the lanes.
    assign word_addr = HADDR[ADDR_WIDTH+1:2];
    assign byte_addr = HADDR[1:0];

    // Strobe, mask and HWDATA all belong to the same data phase.
    assign ram_wr = '{enable: write_enable, mask: write_mask, data: HWDATA};

    ahb_slave_ctrl #(
        .ADDR_WIDTH    (ADDR_WIDTH)
    ) ahb_slave_ctrl_i (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .HSEL          (HSEL),
        .haddr         (word_addr),
        .HTRANS        (HTRANS),
        .HWRITE        (HWRITE),
        .HREADY        (HREADY),
        .read_enable   (read_enable),
        .read_addr     (read_addr),
        .write_enable  (write_enable),
        .write_addr    (write_addr),
        .write_request (write_request)
    );

    ahb_byte_lanes ahb_byte_lanes_i (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .write_request (write_request),
        .HSIZE         (HSIZE),
        .addr_low      (byte_addr),
        .write_mask    (write_mask)
    );

    ram_bank #(
        .ADDR_WIDTH    (ADDR_WIDTH)
    ) ram_bank_i (
        .HCLK          (HCLK),
        .HRESETn       (HRESETn),
        .read_enable   (read_enable),
        .read_addr     (read_addr),
        .write_addr    (write_addr),
        .wr            (ram_wr),
        .read_data     (HRDATA)
    );

endmodule

//--- dv/ahb_ram_tests.svh
`ifndef AHB_RAM_TESTS_SVH
`define AHB_RAM_TESTS_SVH

// Random words are written first and read back afterwards.
task automatic word_rw_test();
    word_addr_t addrs [RW_WORDS];
    @(negedge HCLK);
    check_value("HREADY after reset", 32'h1, 32'(HREADY));
    foreach (addrs[i]) begin
        addrs[i] = word_addr_t'($urandom_range(WORDS - 1));
        write_word(addrs[i], $urandom());
    end
    foreach (addrs[i]) begin
        read_word(addrs[i], ahb_ram_pkg::HTRANS_NONSEQ);
    end
    idle_phase();
endtask

// Every byte lane and both halfword positions are written on top of a
// known word, and each narrow write is followed by a word read.
task automatic narrow_write_test();
    word_addr_t addr;
    for (int w = 0; w < NARROW_WORDS; w++) begin
        addr = word_addr_t'($urandom_range(WORDS - 1));
        write_word(addr, $urandom());
        for (int off = 0; off < 4; off++) begin
            write_narrow({addr, 2'(off)}, ahb_ram_pkg::HSIZE_BYTE, $urandom());
            read_word(addr, ahb_ram_pkg::HTRANS_NONSEQ);
        end
        for (int off = 0; off < 4; off += 2) begin
            write_narrow({addr, 2'(off)}, ahb_ram_pkg::HSIZE_HALF, $urandom());
            read_word(addr, ahb_ram_pkg::HTRANS_SEQ);  // SEQ is a request like NONSEQ.
        end
    end
    idle_phase();
endtask

// A read right behind a write to the same word gets exactly one wait state.
// The wait state belongs to the read's data phase and is the only one of the pair.
task automatic read_after_write_test();
    word_addr_t addr;
    int         waits_before;
    for (int n = 0; n < RAW_WORDS; n++) begin
        addr = word_addr_t'($urandom_range(WORDS - 1));
        waits_before = wait_total;
        write_word(addr, $urandom());
        read_word(addr, ahb_ram_pkg::HTRANS_NONSEQ);
        idle_phase();  // Ends the read's data phase.
        check_value("HREADY low cycles", 32'd1, 32'(last_wait));
        check_value("HREADY low cycles per pair", 32'd1, 32'(wait_total - waits_before));
    end
endtask

// Writes and reads interleave on distinct words.
// Each read trails the write of its own word by one transfer, so no
// read ever meets a write data phase to the same word.
task automatic back_to_back_test();
    word_addr_t addrs [B2B_WORDS];
    word_addr_t base;
    int         waits_before;
    base = word_addr_t'($urandom_range(WORDS - 1));
    foreach (addrs[i]) begin
        addrs[i] = base + word_addr_t'(7 * i);  // Steps of seven words stay distinct across the wrap.
    end
    waits_before = wait_total;
    write_word(addrs[0], $urandom());
    for (int i = 1; i < B2B_WORDS; i++) begin
        write_word(addrs[i], $urandom());
        read_word(addrs[i-1], ahb_ram_pkg::HTRANS_SEQ);
    end
    read_word(addrs[B2B_WORDS-1], ahb_ram_pkg::HTRANS_SEQ);
    idle_phase();
    check_value("HREADY low cycles", 32'd0, 32'(wait_total - waits_before));
endtask

// IDLE, BUSY and unselected write phases must not reach the RAM.
task automatic ignored_transfer_test();
    word_addr_t addrs [IGNORE_WORDS];
    foreach (addrs[i]) begin
        addrs[i] = word_addr_t'($urandom_range(WORDS - 1));
        write_word(addrs[i], $urandom());
    end
    foreach (addrs[i]) begin
        bus_phase(1'b1, ahb_ram_pkg::HTRANS_IDLE, 1'b1, {addrs[i], 2'b00},
                  ahb_ram_pkg::HSIZE_WORD, $urandom());
        bus_phase(1'b1, ahb_ram_pkg::HTRANS_BUSY, 1'b1, {addrs[i], 2'b00},
                  ahb_ram_pkg::HSIZE_WORD, $urandom());
        bus_phase(1'b0, ahb_ram_pkg::HTRANS_NONSEQ, 1'b1, {addrs[i], 2'b00},
                  ahb_ram_pkg::HSIZE_WORD, $urandom());
    end
    foreach (addrs[i]) begin
        read_word(addrs[i], ahb_ram_pkg::HTRANS_NONSEQ);
    end
    idle_phase();
endtask

`endif

//--- dv/tb_ahb_ram.sv
module tb_ahb_ram;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_WIDTH = 10;
    localparam int WORDS      = 2 ** ADDR_WIDTH;
    localparam int CLK_PERIOD = 100;

    // Words touched by each directed test.
    localparam int RW_WORDS     = 16;
    localparam int NARROW_WORDS = 4;
    localparam int RAW_WORDS    = 8;
    localparam int B2B_WORDS    = 16;
    localparam int IGNORE_WORDS = 8;

    // Address phases issued by each test, the closing idle phase included.
    localparam int TRANSFER_COUNT = (2 * RW_WORDS + 1) + (13 * NARROW_WORDS + 1) +
                                    (3 * RAW_WORDS) + (2 * B2B_WORDS + 1) +
                                    (5 * IGNORE_WORDS + 1);

    typedef logic [ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [ADDR_WIDTH+1:0] byte_addr_t;

    // What the driver remembers about a transfer until its data phase ends.
    typedef struct packed {
        logic               valid;     // The address phase was a real request.
        logic               write;
        word_addr_t         addr;
        ahb_ram_pkg::data_t wdata;     // Driven on HWDATA in the data phase.
        ahb_ram_pkg::data_t expected;  // Read data taken from the model.
    } data_phase_t;

    logic                  HCLK = 1'b0;
    logic                  HRESETn;
    logic                  HSEL;
    byte_addr_t            HADDR;
    ahb_ram_pkg::htrans_t  HTRANS;
    ahb_ram_pkg::hsize_t   HSIZE;
    logic                  HWRITE;
    ahb_ram_pkg::data_t    HWDATA;
    logic                  HREADY;
    ahb_ram_pkg::data_t    HRDATA;

    ahb_ram_pkg::data_t model_mem [WORDS];  // Reference copy of the RAM.
    data_phase_t        pending;
    int                 errors;
    int                 checks;
    int                 wait_total;         // HREADY low cycles seen so far.
    int                 last_wait;          // HREADY low cycles of the last data phase.

    ahb_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ahb_ram_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (HSEL),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HSIZE      (HSIZE),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .HREADY     (HREADY),
        .HRDATA     (HRDATA)
    );

    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    task automatic check_value(input string name, input ahb_ram_pkg::data_t expected,
                               input ahb_ram_pkg::data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    // An aligned transfer of 2**size bytes covers the lanes that share
    // its byte offset divided by the transfer length.
    function automatic ahb_ram_pkg::byte_mask_t lanes_for(input ahb_ram_pkg::hsize_t size,
                                                          input logic [1:0] low);
        int                      bytes;
        ahb_ram_pkg::byte_mask_t lanes;
        bytes = 1 << size;
        lanes = '0;
        for (int i = 0; i < 4; i++) begin
            lanes[i] = ((i / bytes) == (int'(low) / bytes));
        end
        return lanes;
    endfunction

    function automatic void model_write(input word_addr_t addr,
                                        input ahb_ram_pkg::byte_mask_t lanes,
                                        input ahb_ram_pkg::data_t data);
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                model_mem[addr][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endfunction

    task automatic init_inputs();
        HRESETn <= 1'b0;
        HSEL    <= 1'b0;
        HADDR   <= '0;
        HTRANS  <= ahb_ram_pkg::HTRANS_IDLE;
        HSIZE   <= ahb_ram_pkg::HSIZE_WORD;
        HWRITE  <= 1'b0;
        HWDATA  <= '0;
    endtask

    task automatic apply_reset();
        repeat (5) @(posedge HCLK);
        HRESETn <= 1'b1;
    endtask

    // Presents one address phase and returns once the slave accepts it.
    // That is also the end of the previous transfer's data phase.
    task automatic bus_phase(input logic sel, input ahb_ram_pkg::htrans_t trans,
                             input logic write, input byte_addr_t addr,
                             input ahb_ram_pkg::hsize_t size, input ahb_ram_pkg::data_t wdata);
        data_phase_t issued;
        int          stalls;
        issued.valid    = sel && (trans == ahb_ram_pkg::HTRANS_NONSEQ ||
                                  trans == ahb_ram_pkg::HTRANS_SEQ);
        issued.write    = write;
        issued.addr     = addr[ADDR_WIDTH+1:2];
        issued.wdata    = wdata;
        issued.expected = '0;
        if (issued.valid && write) begin
            model_write(issued.addr, lanes_for(size, addr[1:0]), wdata);
        end else if (issued.valid) begin
            issued.expected = model_mem[issued.addr];  // Model already holds earlier writes.
        end
        @(posedge HCLK);
        HSEL   <= sel;
        HADDR  <= addr;
        HTRANS <= trans;
        HSIZE  <= size;
        HWRITE <= write;
        if (pending.valid && pending.write) begin
            HWDATA <= pending.wdata;
        end else begin
            HWDATA <= $urandom();  // Noise on the bus when no write data is due.
        end
        stalls = 0;
        @(negedge HCLK);
        while (HREADY !== 1'b1) begin
            stalls++;
            @(negedge HCLK);
        end
        wait_total += stalls;
        if (pending.valid) begin
            last_wait = stalls;
            if (!pending.write) begin
                check_value($sformatf("HRDATA word 0x%h", pending.addr),
                            pending.expected, HRDATA);
            end
        end
        pending = issued;
    endtask

    task automatic write_word(input word_addr_t addr, input ahb_ram_pkg::data_t data);
        bus_phase(1'b1, ahb_ram_pkg::HTRANS_NONSEQ, 1'b1, {addr, 2'b00},
                  ahb_ram_pkg::HSIZE_WORD, data);
    endtask

    task automatic write_narrow(input byte_addr_t addr, input ahb_ram_pkg::hsize_t size,
                                input ahb_ram_pkg::data_t data);
        bus_phase(1'b1, ahb_ram_pkg::HTRANS_NONSEQ, 1'b1, addr, size, data);
    endtask

    task automatic read_word(input word_addr_t addr, input ahb_ram_pkg::htrans_t trans);
        bus_phase(1'b1, trans, 1'b0, {addr, 2'b00}, ahb_ram_pkg::HSIZE_WORD, '0);
    endtask

    task automatic idle_phase();
        bus_phase(1'b1, ahb_ram_pkg::HTRANS_IDLE, 1'b0, '0, ahb_ram_pkg::HSIZE_WORD, '0);
    endtask

    `include "ahb_ram_tests.svh"

    initial begin
        pending    = '0;
        errors     = 0;
        checks     = 0;
        wait_total = 0;
        last_wait  = 0;
        void'($urandom(32'h8b7f_0a95));
        init_inputs();
        apply_reset();
        word_rw_test();
        narrow_write_test();
        read_after_write_test();
        back_to_back_test();
        ignored_transfer_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Four clock periods per transfer leaves room for reset and wait states.
    initial begin
        #(TRANSFER_COUNT * 4 * CLK_PERIOD);
        $display("Timeout: the tests did not complete within %0d ns",
                 TRANSFER_COUNT * 4 * CLK_PERIOD);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- all.f
hdl/ahb_ram_pkg.sv
hdl/ahb_slave_ctrl.sv
hdl/ahb_byte_lanes.sv
hdl/ram_bank.sv
hdl/ahb_ram.sv
dv/tb_ahb_ram.sv
+incdir+dv

//--- Makefile
TOP := tb_ahb_ram

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^Regression passed$$" sim.log || \
		{ echo "Simulation did not pass, see sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
